//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f axi_mem.f --top-module axi_mem_tb -o axi_mem_sim
	./obj_dir/axi_mem_sim

clean:
	rm -rf obj_dir

//--- axi_mem.f
+incdir+include
logic/axi_mem_pkg.sv
logic/axi_mem_cmd_fifo.sv
logic/axi_mem_storage.sv
logic/axi_mem_write_engine.sv
logic/axi_mem_read_engine.sv
logic/axi_mem_top.sv
verification/axi_mem_properties.sv
verification/axi_mem_tb.sv

//--- include/axi_mem_defs.svh
/*
  Width and depth constants of the AXI memory slave.
  Included by the package and by every module that sizes a port.
*/
`ifndef AXI_MEM_DEFS_SVH
`define AXI_MEM_DEFS_SVH

// Bus widths
`define AXI_MEM_ADDR_WIDTH 32
`define AXI_MEM_DATA_WIDTH 32
`define AXI_MEM_STRB_WIDTH 4
`define AXI_MEM_ID_WIDTH 4

// Burst length field holds beats minus one
`define AXI_MEM_LEN_WIDTH 8

// Storage and queue sizes
`define AXI_MEM_WORDS 256
`define AXI_MEM_QUEUE_DEPTH 4

`endif

//--- logic/axi_mem_cmd_fifo.sv
/*
  Circular queue of burst commands between an address channel and an engine.
  The head is always visible on cmd_o; the engine pops it when the burst ends.
*/
`timescale 1ns/10ps
`default_nettype none

module axi_mem_cmd_fifo import axi_mem_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     push_i,
  input  axi_cmd_t cmd_i,
  input  logic     pop_i,
  output axi_cmd_t cmd_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  axi_cmd_t         entries [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(DEPTH));
  assign cmd_o   = entries[rd_ptr];

  // Pushes into a full queue and pops from an empty one are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      entries[wr_ptr] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the fill level unchanged
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/axi_mem_pkg.sv
/*
  Shared types of the AXI memory slave: burst and state enums, the queued
  command and the beat address rule used by both engines.
*/
`default_nettype none

`include "axi_mem_defs.svh"

package axi_mem_pkg;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1
  } burst_e;

  typedef enum logic {
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // One AW or AR command as it sits in a queue
  typedef struct packed {
    logic [`AXI_MEM_ID_WIDTH-1:0]   id;
    logic [`AXI_MEM_ADDR_WIDTH-1:0] addr;
    logic [`AXI_MEM_LEN_WIDTH-1:0]  len;
    burst_e                         burst;
  } axi_cmd_t;

  // Word-aligned address of beat n; encodings other than FIXED behave as INCR
  function automatic logic [`AXI_MEM_ADDR_WIDTH-1:0] beat_addr(
    input logic [`AXI_MEM_ADDR_WIDTH-1:0] addr,
    input burst_e                         burst,
    input logic [`AXI_MEM_LEN_WIDTH-1:0]  n
  );
    logic [`AXI_MEM_ADDR_WIDTH-1:0] base;
    base = addr & ~(`AXI_MEM_ADDR_WIDTH'(`AXI_MEM_STRB_WIDTH - 1));
    if (burst == BURST_FIXED) begin
      return base;
    end
    return base + `AXI_MEM_ADDR_WIDTH'(n) * `AXI_MEM_ADDR_WIDTH'(`AXI_MEM_STRB_WIDTH);
  endfunction

endpackage

`default_nettype wire

//--- logic/axi_mem_read_engine.sv
/*
  Walks the head read command beat by beat and presents R beats straight
  from storage. The command leaves the queue on its last R transfer.
*/
`timescale 1ns/10ps
`default_nettype none

`include "axi_mem_defs.svh"

module axi_mem_read_engine import axi_mem_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  axi_cmd_t                       cmd_i,
  input  logic                           cmd_empty_i,
  output logic                           cmd_pop_o,
  output logic [`AXI_MEM_ADDR_WIDTH-1:0] raddr_o,
  input  logic [`AXI_MEM_DATA_WIDTH-1:0] rdata_i,
  output logic                           r_valid_o,
  output logic [`AXI_MEM_DATA_WIDTH-1:0] r_data_o,
  output logic [`AXI_MEM_ID_WIDTH-1:0]   r_id_o,
  output logic                           r_last_o,
  input  logic                           r_ready_i
);

  logic [`AXI_MEM_LEN_WIDTH-1:0] beat_cnt;
  logic                          r_fire;

  // Address of the beat currently on the R channel
  assign raddr_o = beat_addr(cmd_i.addr, cmd_i.burst, beat_cnt);

  assign r_valid_o = ~cmd_empty_i;
  assign r_data_o  = rdata_i;
  assign r_id_o    = cmd_i.id;
  assign r_last_o  = (beat_cnt == cmd_i.len);

  assign r_fire    = r_valid_o & r_ready_i;
  assign cmd_pop_o = r_fire & r_last_o;

  // Count only moves on a transfer, so a stalled beat stays put
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_cnt <= '0;
    end else if (r_fire) begin
      if (r_last_o) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/axi_mem_storage.sv
/*
  Word memory with one byte-strobed write port and one combinational read port.
  Addresses wrap modulo the memory size.
*/
`timescale 1ns/10ps
`default_nettype none

`include "axi_mem_defs.svh"

module axi_mem_storage (
  input  logic                           clk_i,
  input  logic                           we_i,
  input  logic [`AXI_MEM_ADDR_WIDTH-1:0] waddr_i,
  input  logic [`AXI_MEM_DATA_WIDTH-1:0] wdata_i,
  input  logic [`AXI_MEM_STRB_WIDTH-1:0] wstrb_i,
  input  logic [`AXI_MEM_ADDR_WIDTH-1:0] raddr_i,
  output logic [`AXI_MEM_DATA_WIDTH-1:0] rdata_o
);

  localparam int IDX_W = $clog2(`AXI_MEM_WORDS);
  localparam int OFF_W = $clog2(`AXI_MEM_STRB_WIDTH);

  logic [`AXI_MEM_DATA_WIDTH-1:0] mem [`AXI_MEM_WORDS];
  logic [IDX_W-1:0]               widx;
  logic [IDX_W-1:0]               ridx;

  // Word index sits just above the byte offset
  assign widx = waddr_i[OFF_W +: IDX_W];
  assign ridx = raddr_i[OFF_W +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < `AXI_MEM_STRB_WIDTH; b++) begin
        if (wstrb_i[b]) begin
          mem[widx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Old contents are seen when reading a word written in the same cycle
  assign rdata_o = mem[ridx];

endmodule

`default_nettype wire

//--- logic/axi_mem_top.sv
/*
  Single-port AXI-style memory slave. AW and AR commands are queued, the
  write and read engines drain the queues into and out of a shared storage.
*/
`timescale 1ns/10ps
`default_nettype none

`include "axi_mem_defs.svh"

module axi_mem_top import axi_mem_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // AW
  input  logic                           aw_valid_i,
  output logic                           aw_ready_o,
  input  logic [`AXI_MEM_ID_WIDTH-1:0]   aw_id_i,
  input  logic [`AXI_MEM_ADDR_WIDTH-1:0] aw_addr_i,
  input  logic [`AXI_MEM_LEN_WIDTH-1:0]  aw_len_i,
  input  logic [1:0]                     aw_burst_i,
  // W
  input  logic                           w_valid_i,
  output logic                           w_ready_o,
  input  logic [`AXI_MEM_DATA_WIDTH-1:0] w_data_i,
  input  logic [`AXI_MEM_STRB_WIDTH-1:0] w_strb_i,
  input  logic                           w_last_i,
  // B
  output logic                           b_valid_o,
  input  logic                           b_ready_i,
  output logic [`AXI_MEM_ID_WIDTH-1:0]   b_id_o,
  // AR
  input  logic                           ar_valid_i,
  output logic                           ar_ready_o,
  input  logic [`AXI_MEM_ID_WIDTH-1:0]   ar_id_i,
  input  logic [`AXI_MEM_ADDR_WIDTH-1:0] ar_addr_i,
  input  logic [`AXI_MEM_LEN_WIDTH-1:0]  ar_len_i,
  input  logic [1:0]                     ar_burst_i,
  // R
  output logic                           r_valid_o,
  input  logic                           r_ready_i,
  output logic [`AXI_MEM_DATA_WIDTH-1:0] r_data_o,
  output logic [`AXI_MEM_ID_WIDTH-1:0]   r_id_o,
  output logic                           r_last_o,
  // Write monitor
  output logic                           mon_w_valid_o,
  output logic [`AXI_MEM_ADDR_WIDTH-1:0] mon_w_addr_o,
  output logic [`AXI_MEM_DATA_WIDTH-1:0] mon_w_data_o,
  output logic [`AXI_MEM_LEN_WIDTH-1:0]  mon_w_beat_o,
  output logic                           mon_w_last_o
);

  axi_cmd_t                       aw_cmd;
  axi_cmd_t                       ar_cmd;
  axi_cmd_t                       aw_head;
  axi_cmd_t                       ar_head;
  logic                           aw_empty;
  logic                           ar_empty;
  logic                           aw_full;
  logic                           ar_full;
  logic                           aw_pop;
  logic                           ar_pop;
  logic                           we;
  logic [`AXI_MEM_ADDR_WIDTH-1:0] waddr;
  logic [`AXI_MEM_DATA_WIDTH-1:0] wdata;
  logic [`AXI_MEM_STRB_WIDTH-1:0] wstrb;
  logic [`AXI_MEM_ADDR_WIDTH-1:0] raddr;
  logic [`AXI_MEM_DATA_WIDTH-1:0] rdata;

  assign aw_cmd = '{id: aw_id_i, addr: aw_addr_i, len: aw_len_i, burst: burst_e'(aw_burst_i)};
  assign ar_cmd = '{id: ar_id_i, addr: ar_addr_i, len: ar_len_i, burst: burst_e'(ar_burst_i)};

  assign aw_ready_o = ~aw_full;
  assign ar_ready_o = ~ar_full;

  axi_mem_cmd_fifo #(
    .DEPTH (`AXI_MEM_QUEUE_DEPTH)
  ) aw_fifo_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (aw_valid_i & aw_ready_o),
    .cmd_i   (aw_cmd),
    .pop_i   (aw_pop),
    .cmd_o   (aw_head),
    .empty_o (aw_empty),
    .full_o  (aw_full)
  );

  axi_mem_cmd_fifo #(
    .DEPTH (`AXI_MEM_QUEUE_DEPTH)
  ) ar_fifo_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (ar_valid_i & ar_ready_o),
    .cmd_i   (ar_cmd),
    .pop_i   (ar_pop),
    .cmd_o   (ar_head),
    .empty_o (ar_empty),
    .full_o  (ar_full)
  );

  axi_mem_write_engine write_engine_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_i         (aw_head),
    .cmd_empty_i   (aw_empty),
    .cmd_pop_o     (aw_pop),
    .w_valid_i     (w_valid_i),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .w_last_i      (w_last_i),
    .w_ready_o     (w_ready_o),
    .b_valid_o     (b_valid_o),
    .b_id_o        (b_id_o),
    .b_ready_i     (b_ready_i),
    .we_o          (we),
    .waddr_o       (waddr),
    .wdata_o       (wdata),
    .wstrb_o       (wstrb),
    .mon_w_valid_o (mon_w_valid_o),
    .mon_w_addr_o  (mon_w_addr_o),
    .mon_w_data_o  (mon_w_data_o),
    .mon_w_beat_o  (mon_w_beat_o),
    .mon_w_last_o  (mon_w_last_o)
  );

  axi_mem_read_engine read_engine_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_i       (ar_head),
    .cmd_empty_i (ar_empty),
    .cmd_pop_o   (ar_pop),
    .raddr_o     (raddr),
    .rdata_i     (rdata),
    .r_valid_o   (r_valid_o),
    .r_data_o    (r_data_o),
    .r_id_o      (r_id_o),
    .r_last_o    (r_last_o),
    .r_ready_i   (r_ready_i)
  );

  axi_mem_storage storage_i (
    .clk_i   (clk_i),
    .we_i    (we),
    .waddr_i (waddr),
    .wdata_i (wdata),
    .wstrb_i (wstrb),
    .raddr_i (raddr),
    .rdata_o (rdata)
  );

endmodule

`default_nettype wire

//--- logic/axi_mem_write_engine.sv
/*
  Accepts W beats for the head write command, writes them into storage and
  returns one B response per burst. Each stored beat is echoed on the monitor
  outputs one cycle later.
*/
`timescale 1ns/10ps
`default_nettype none

`include "axi_mem_defs.svh"

module axi_mem_write_engine import axi_mem_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  axi_cmd_t                       cmd_i,
  input  logic                           cmd_empty_i,
  output logic                           cmd_pop_o,
  input  logic                           w_valid_i,
  input  logic [`AXI_MEM_DATA_WIDTH-1:0] w_data_i,
  input  logic [`AXI_MEM_STRB_WIDTH-1:0] w_strb_i,
  input  logic                           w_last_i,
  output logic                           w_ready_o,
  output logic                           b_valid_o,
  output logic [`AXI_MEM_ID_WIDTH-1:0]   b_id_o,
  input  logic                           b_ready_i,
  output logic                           we_o,
  output logic [`AXI_MEM_ADDR_WIDTH-1:0] waddr_o,
  output logic [`AXI_MEM_DATA_WIDTH-1:0] wdata_o,
  output logic [`AXI_MEM_STRB_WIDTH-1:0] wstrb_o,
  output logic                           mon_w_valid_o,
  output logic [`AXI_MEM_ADDR_WIDTH-1:0] mon_w_addr_o,
  output logic [`AXI_MEM_DATA_WIDTH-1:0] mon_w_data_o,
  output logic [`AXI_MEM_LEN_WIDTH-1:0]  mon_w_beat_o,
  output logic                           mon_w_last_o
);

  wr_state_e                     state;
  logic [`AXI_MEM_LEN_WIDTH-1:0] beat_cnt;
  logic                          w_fire;
  logic                          last_beat;

  // W is only taken while a command is queued and no B is outstanding
  assign w_ready_o = ~cmd_empty_i & (state == WR_DATA);
  assign w_fire    = w_valid_i & w_ready_o;
  assign last_beat = (beat_cnt == cmd_i.len);
  assign cmd_pop_o = w_fire & last_beat;

  // Storage write port
  assign we_o    = w_fire;
  assign waddr_o = beat_addr(cmd_i.addr, cmd_i.burst, beat_cnt);
  assign wdata_o = w_data_i;
  assign wstrb_o = w_strb_i;

  assign b_valid_o = (state == WR_RESP);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state    <= WR_DATA;
      beat_cnt <= '0;
    end else begin
      case (state)
        WR_DATA: begin
          if (w_fire) begin
            if (last_beat) begin
              beat_cnt <= '0;
              state    <= WR_RESP;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        WR_RESP: begin
          if (b_ready_i) begin
            state <= WR_DATA;
          end
        end
        default: state <= WR_DATA;
      endcase
    end
  end

  // Response id is latched with the last beat before the command leaves the queue
  always_ff @(posedge clk_i) begin
    if (cmd_pop_o) begin
      b_id_o <= cmd_i.id;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mon_w_valid_o <= 1'b0;
    end else begin
      mon_w_valid_o <= w_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_fire) begin
      mon_w_addr_o <= waddr_o;
      mon_w_data_o <= w_data_i;
      mon_w_beat_o <= beat_cnt;
      mon_w_last_o <= last_beat;
    end
  end

endmodule

`default_nettype wire

//--- verification/axi_mem_properties.sv
/*
  Channel protocol assertions for the AXI memory slave.
  Bound to axi_mem_top from this file.
*/
`timescale 1ns/10ps
`default_nettype none

`include "axi_mem_defs.svh"

module axi_mem_properties (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           w_valid_i,
  input logic                           w_ready_o,
  input logic                           w_last_i,
  input logic                           b_valid_o,
  input logic                           b_ready_i,
  input logic [`AXI_MEM_ID_WIDTH-1:0]   b_id_o,
  input logic                           r_valid_o,
  input logic                           r_ready_i,
  input logic [`AXI_MEM_DATA_WIDTH-1:0] r_data_o,
  input logic [`AXI_MEM_ID_WIDTH-1:0]   r_id_o,
  input logic                           r_last_o,
  input logic                           mon_w_valid_o,
  input logic                           mon_w_last_o,
  input logic                           aw_pop_i
);

  // A pending B holds until accepted
  b_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o))
    else $error("B channel changed while stalled");

  r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_id_o)
      && $stable(r_last_o))
    else $error("R channel changed while stalled");

  // The final W beat closes W and raises B on the next cycle
  w_blocked: assert property (@(posedge clk_i) disable iff (rst_i)
    (w_valid_i && w_ready_o && w_last_i) |=> b_valid_o && !w_ready_o)
    else $error("W still open after the final beat");

  // The monitor echoes each W transfer one cycle later with its WLAST
  mon_follows: assert property (@(posedge clk_i) disable iff (rst_i)
    (w_valid_i && w_ready_o) |=> mon_w_valid_o && (mon_w_last_o == $past(w_last_i)))
    else $error("Monitor missed a W transfer");

  // The engine pops its command on the final beat, which must carry WLAST
  last_match: assert property (@(posedge clk_i) disable iff (rst_i)
    (w_valid_i && w_ready_o) |-> (w_last_i == aw_pop_i))
    else $error("WLAST does not match the final beat");

endmodule

bind axi_mem_top axi_mem_properties props_i (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .w_valid_i     (w_valid_i),
  .w_ready_o     (w_ready_o),
  .w_last_i      (w_last_i),
  .b_valid_o     (b_valid_o),
  .b_ready_i     (b_ready_i),
  .b_id_o        (b_id_o),
  .r_valid_o     (r_valid_o),
  .r_ready_i     (r_ready_i),
  .r_data_o      (r_data_o),
  .r_id_o        (r_id_o),
  .r_last_o      (r_last_o),
  .mon_w_valid_o (mon_w_valid_o),
  .mon_w_last_o  (mon_w_last_o),
  .aw_pop_i      (aw_pop)
);

`default_nettype wire

//--- verification/axi_mem_tb.sv
/*
  Testbench for the AXI memory slave. Drives the AW, W, AR channels,
  models the memory and checks every B, R and monitor beat against it.
*/
`timescale 1ns/10ps
`default_nettype none

`include "axi_mem_defs.svh"

module axi_mem_tb import axi_mem_pkg::*; ;

  // Fill plus all bursts and stalls take a few thousand cycles
  localparam int CYCLE_LIMIT = 20000;

  logic                           clk_i;
  logic                           rst_i;
  logic                           aw_valid_i;
  logic                           aw_ready_o;
  logic [`AXI_MEM_ID_WIDTH-1:0]   aw_id_i;
  logic [`AXI_MEM_ADDR_WIDTH-1:0] aw_addr_i;
  logic [`AXI_MEM_LEN_WIDTH-1:0]  aw_len_i;
  logic [1:0]                     aw_burst_i;
  logic                           w_valid_i;
  logic                           w_ready_o;
  logic [`AXI_MEM_DATA_WIDTH-1:0] w_data_i;
  logic [`AXI_MEM_STRB_WIDTH-1:0] w_strb_i;
  logic                           w_last_i;
  logic                           b_valid_o;
  logic                           b_ready_i;
  logic [`AXI_MEM_ID_WIDTH-1:0]   b_id_o;
  logic                           ar_valid_i;
  logic                           ar_ready_o;
  logic [`AXI_MEM_ID_WIDTH-1:0]   ar_id_i;
  logic [`AXI_MEM_ADDR_WIDTH-1:0] ar_addr_i;
  logic [`AXI_MEM_LEN_WIDTH-1:0]  ar_len_i;
  logic [1:0]                     ar_burst_i;
  logic                           r_valid_o;
  logic                           r_ready_i;
  logic [`AXI_MEM_DATA_WIDTH-1:0] r_data_o;
  logic [`AXI_MEM_ID_WIDTH-1:0]   r_id_o;
  logic                           r_last_o;
  logic                           mon_w_valid_o;
  logic [`AXI_MEM_ADDR_WIDTH-1:0] mon_w_addr_o;
  logic [`AXI_MEM_DATA_WIDTH-1:0] mon_w_data_o;
  logic [`AXI_MEM_LEN_WIDTH-1:0]  mon_w_beat_o;
  logic                           mon_w_last_o;

  // Reference model and expectation queues
  logic [`AXI_MEM_DATA_WIDTH-1:0] ref_mem [`AXI_MEM_WORDS];
  axi_cmd_t                       wq[$];
  axi_cmd_t                       rq[$];
  logic [`AXI_MEM_ID_WIDTH-1:0]   bq[$];
  axi_cmd_t                       cur_w;
  axi_cmd_t                       cur_r;
  logic [`AXI_MEM_ADDR_WIDTH-1:0] w_addr;
  int                             w_idx;
  int                             w_beat;
  int                             r_beat;
  logic                           mon_due;
  logic [`AXI_MEM_ADDR_WIDTH-1:0] mon_addr;
  logic [`AXI_MEM_DATA_WIDTH-1:0] mon_data;
  logic [`AXI_MEM_LEN_WIDTH-1:0]  mon_beat;
  logic                           mon_last;
  int                             b_count;
  int                             r_bursts;
  int                             w_issued;
  int                             r_issued;
  int                             cycles;
  logic                           stall_mode;
  logic [`AXI_MEM_ADDR_WIDTH-1:0] q_addr [4];
  logic [`AXI_MEM_LEN_WIDTH-1:0]  q_len [4];
  logic [`AXI_MEM_ID_WIDTH-1:0]   q_id [4];

  axi_mem_top dut_i (.*);

  always #5 clk_i = ~clk_i;

  // Word-aligned address of beat n; FIXED stays on the start word
  function automatic logic [`AXI_MEM_ADDR_WIDTH-1:0] expected_addr(
    input logic [`AXI_MEM_ADDR_WIDTH-1:0] addr,
    input burst_e                         burst,
    input int                             n
  );
    logic [`AXI_MEM_ADDR_WIDTH-1:0] base;
    base = {addr[`AXI_MEM_ADDR_WIDTH-1:2], 2'b00};
    if (burst == BURST_FIXED) begin
      return base;
    end
    return base + `AXI_MEM_ADDR_WIDTH'(n * 4);
  endfunction

  function automatic int word_index(input logic [`AXI_MEM_ADDR_WIDTH-1:0] addr);
    return int'(addr >> 2) % `AXI_MEM_WORDS;
  endfunction

  function automatic logic [`AXI_MEM_DATA_WIDTH-1:0] merge_bytes(
    input logic [`AXI_MEM_DATA_WIDTH-1:0] old_word,
    input logic [`AXI_MEM_DATA_WIDTH-1:0] data,
    input logic [`AXI_MEM_STRB_WIDTH-1:0] strb
  );
    logic [`AXI_MEM_DATA_WIDTH-1:0] res;
    res = old_word;
    for (int b = 0; b < `AXI_MEM_STRB_WIDTH; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [`AXI_MEM_DATA_WIDTH-1:0] expected_word(
    input axi_cmd_t cmd,
    input int       n
  );
    return ref_mem[word_index(expected_addr(cmd.addr, cmd.burst, n))];
  endfunction

  // Fill value mixes every bit of the word address
  function automatic logic [`AXI_MEM_DATA_WIDTH-1:0] fill_word(input int i);
    logic [7:0] a;
    a = 8'(i);
    return {a, a ^ 8'ha5, ~a, {a[3:0], a[7:4]} ^ 8'h3c};
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic unexpected_event(input string msg);
    $display("Unexpected DUT behavior: %s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_data(input logic [`AXI_MEM_DATA_WIDTH-1:0] got,
                            input logic [`AXI_MEM_DATA_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_addr(input logic [`AXI_MEM_ADDR_WIDTH-1:0] got,
                            input logic [`AXI_MEM_ADDR_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_id(input logic [`AXI_MEM_ID_WIDTH-1:0] got,
                          input logic [`AXI_MEM_ID_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_beat(input logic [`AXI_MEM_LEN_WIDTH-1:0] got,
                            input logic [`AXI_MEM_LEN_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    end
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  // Ready lines stall at random only while stall_mode is set
  always @(negedge clk_i) begin
    if (stall_mode) begin
      b_ready_i = ($urandom % 3) != 0;
      r_ready_i = ($urandom % 3) != 0;
    end else begin
      b_ready_i = 1'b1;
      r_ready_i = 1'b1;
    end
  end

  // Compare process samples at the edge where transfers happen
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (mon_due) begin
        check_flag(mon_w_valid_o, 1'b1, "monitor valid");
        check_addr(mon_w_addr_o, mon_addr, "monitor address");
        check_data(mon_w_data_o, mon_data, "monitor data");
        check_beat(mon_w_beat_o, mon_beat, "monitor beat");
        check_flag(mon_w_last_o, mon_last, "monitor last");
      end else if (mon_w_valid_o) begin
        unexpected_event("monitor beat without a W transfer");
      end
      mon_due = 1'b0;

      // R is checked before the W update since memory still holds the old word here
      if (r_valid_o && r_ready_i) begin
        if (rq.size() == 0) begin
          unexpected_event("R beat without a read command");
        end else begin
          cur_r = rq[0];
          check_data(r_data_o, expected_word(cur_r, r_beat), "R data");
          check_id(r_id_o, cur_r.id, "R id");
          check_flag(r_last_o, r_beat == int'(cur_r.len), "R last");
          if (r_beat == int'(cur_r.len)) begin
            void'(rq.pop_front());
            r_beat = 0;
            r_bursts++;
          end else begin
            r_beat++;
          end
        end
      end

      if (b_valid_o && b_ready_i) begin
        if (bq.size() == 0) begin
          unexpected_event("B response without a finished write burst");
        end else begin
          check_id(b_id_o, bq.pop_front(), "B id");
          b_count++;
        end
      end

      if (aw_valid_i && aw_ready_o) begin
        wq.push_back(axi_cmd_t'{id: aw_id_i, addr: aw_addr_i, len: aw_len_i,
                                burst: burst_e'(aw_burst_i)});
      end
      if (ar_valid_i && ar_ready_o) begin
        rq.push_back(axi_cmd_t'{id: ar_id_i, addr: ar_addr_i, len: ar_len_i,
                                burst: burst_e'(ar_burst_i)});
      end

      if (w_valid_i && w_ready_o) begin
        if (wq.size() == 0) begin
          unexpected_event("W beat accepted without a write command");
        end else begin
          cur_w = wq[0];
          w_addr = expected_addr(cur_w.addr, cur_w.burst, w_beat);
          w_idx = word_index(w_addr);
          ref_mem[w_idx] = merge_bytes(ref_mem[w_idx], w_data_i, w_strb_i);
          mon_due = 1'b1;
          mon_addr = w_addr;
          mon_data = w_data_i;
          mon_beat = `AXI_MEM_LEN_WIDTH'(w_beat);
          mon_last = (w_beat == int'(cur_w.len));
          if (mon_last) begin
            bq.push_back(cur_w.id);
            void'(wq.pop_front());
            w_beat = 0;
          end else begin
            w_beat++;
          end
        end
      end
    end
  end

  // Channel tasks start and end on a falling edge
  task automatic send_aw(input logic [3:0] id, input logic [31:0] addr,
                         input logic [7:0] len, input burst_e burst);
    logic fire;
    aw_valid_i = 1'b1;
    aw_id_i = id;
    aw_addr_i = addr;
    aw_len_i = len;
    aw_burst_i = burst;
    fire = 1'b0;
    while (!fire) begin
      fire = aw_ready_o;
      @(negedge clk_i);
    end
    aw_valid_i = 1'b0;
  endtask

  task automatic send_ar(input logic [3:0] id, input logic [31:0] addr,
                         input logic [7:0] len, input burst_e burst);
    logic fire;
    ar_valid_i = 1'b1;
    ar_id_i = id;
    ar_addr_i = addr;
    ar_len_i = len;
    ar_burst_i = burst;
    fire = 1'b0;
    while (!fire) begin
      fire = ar_ready_o;
      @(negedge clk_i);
    end
    ar_valid_i = 1'b0;
    r_issued++;
  endtask

  task automatic send_w(input logic [31:0] data, input logic [3:0] strb, input logic last);
    logic fire;
    w_valid_i = 1'b1;
    w_data_i = data;
    w_strb_i = strb;
    w_last_i = last;
    fire = 1'b0;
    while (!fire) begin
      fire = w_ready_o;
      @(negedge clk_i);
    end
    w_valid_i = 1'b0;
  endtask

  task automatic send_beats(input int len, input logic full_strb);
    for (int i = 0; i <= len; i++) begin
      send_w($urandom, full_strb ? 4'hf : 4'($urandom), i == len);
    end
  endtask

  task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                             input logic [7:0] len, input burst_e burst, input logic full_strb);
    send_aw(id, addr, len, burst);
    send_beats(int'(len), full_strb);
    w_issued++;
    wait (b_count == w_issued);
    @(negedge clk_i);
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                            input logic [7:0] len, input burst_e burst);
    send_ar(id, addr, len, burst);
    wait (r_bursts == r_issued);
    @(negedge clk_i);
  endtask

  initial begin
    logic [31:0] addr;
    logic [7:0]  len;
    logic [3:0]  id;
    void'($urandom(32'h1e27395c));
    clk_i = 1'b0;
    rst_i = 1'b1;
    aw_valid_i = 1'b0;
    aw_id_i = '0;
    aw_addr_i = '0;
    aw_len_i = '0;
    aw_burst_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    w_last_i = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i = '0;
    ar_addr_i = '0;
    ar_len_i = '0;
    ar_burst_i = '0;
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
    stall_mode = 1'b0;
    mon_due = 1'b0;
    w_beat = 0;
    r_beat = 0;
    b_count = 0;
    r_bursts = 0;
    w_issued = 0;
    r_issued = 0;
    cycles = 0;
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);

    // Fill the whole memory with one 256-beat burst so no byte is unknown
    send_aw(4'h0, 32'h0, 8'd255, BURST_INCR);
    for (int i = 0; i < `AXI_MEM_WORDS; i++) begin
      send_w(fill_word(i), 4'hf, i == `AXI_MEM_WORDS - 1);
    end
    w_issued++;
    wait (b_count == w_issued);
    @(negedge clk_i);

    // Single-beat round trip
    write_burst(4'h9, 32'h0000_0040, 8'd0, BURST_INCR, 1'b1);
    read_burst(4'h9, 32'h0000_0040, 8'd0, BURST_INCR);

    // INCR bursts with random strobes
    for (int t = 0; t < 20; t++) begin
      addr = {$urandom} & 32'hffff_fffc;
      len = 8'($urandom % 8);
      id = 4'($urandom);
      write_burst(id, addr, len, BURST_INCR, 1'b0);
      read_burst(4'($urandom), addr, len, BURST_INCR);
    end

    // FIXED bursts merge into one word
    for (int t = 0; t < 4; t++) begin
      addr = {$urandom} & 32'h0000_03fc;
      write_burst(4'($urandom), addr, 8'd3, BURST_FIXED, 1'b0);
      read_burst(4'($urandom), addr, 8'd3, BURST_FIXED);
    end

    // Four queued commands under random back-pressure
    stall_mode = 1'b1;
    for (int k = 0; k < 4; k++) begin
      q_addr[k] = {$urandom} & 32'h0000_03fc;
      q_len[k] = 8'($urandom % 6);
      q_id[k] = 4'($urandom);
      send_aw(q_id[k], q_addr[k], q_len[k], BURST_INCR);
    end
    for (int k = 0; k < 4; k++) begin
      send_beats(int'(q_len[k]), 1'b0);
    end
    w_issued += 4;
    wait (b_count == w_issued);
    @(negedge clk_i);
    for (int k = 0; k < 4; k++) begin
      send_ar(q_id[k], q_addr[k], q_len[k], BURST_INCR);
    end
    wait (r_bursts == r_issued);
    @(negedge clk_i);
    stall_mode = 1'b0;
    repeat (4) @(negedge clk_i);

    if (wq.size() != 0 || rq.size() != 0 || bq.size() != 0 || mon_due) begin
      $display("Transactions still outstanding at the end of the run");
      $display("Simulation failed");
      $fatal(1);
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire
